// File: Bender.yml
package:
  name: vlcm

sources:
  - include_dirs:
      - hw
    files:
      - hw/vlcm_pkg.sv
      - hw/gcd_engine.sv
      - hw/seq_divider.sv
      - hw/scalar_lcm.sv
      - hw/vector_lcm.sv
      - hw/vlcm_top.sv
  - target: test
    files:
      - verif/vlcm_tb.sv

// File: build.f
+incdir+hw
hw/vlcm_pkg.sv
hw/gcd_engine.sv
hw/seq_divider.sv
hw/scalar_lcm.sv
hw/vector_lcm.sv
hw/vlcm_top.sv
verif/vlcm_tb.sv

// File: hw/gcd_engine.sv
/*
 * Subtractive GCD engine
 * Subtracts the smaller register from the larger one per cycle until
 * both match; a zero operand returns zero right away
 */

`default_nettype none

module gcd_engine (
  input  wire logic            CLK,
  input  wire logic            RST,
  input  wire logic            start,
  input  wire vlcm_pkg::data_t op_a,
  input  wire vlcm_pkg::data_t op_b,
  output logic                 done,
  output vlcm_pkg::data_t      gcd
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic            busy;
  logic            zero_op;
  // Working pair, reduced in place
  vlcm_pkg::data_t x_q;
  vlcm_pkg::data_t y_q;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // gcd(x, 0) handled as zero, lcm is zero anyway
  assign zero_op = (op_a == '0) || (op_b == '0);

  // Busy flag and done pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // Zero operand retires in the start cycle
        if (zero_op) begin
          done <= 1'b1;
        end else begin
          busy <= 1'b1;
        end
      end else if (busy && (x_q == y_q)) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Subtraction datapath
  always_ff @(posedge CLK) begin
    if (start) begin
      x_q <= op_a;
      y_q <= op_b;
      if (zero_op) begin
        gcd <= '0;
      end
    end else if (busy) begin
      if (x_q > y_q) begin
        x_q <= x_q - y_q;
      end else if (y_q > x_q) begin
        y_q <= y_q - x_q;
      end else begin
        // Converged
        gcd <= x_q;
      end
    end
  end

  // Caller waits for done before the next start
  start_when_idle: assert property (@(posedge CLK) disable iff (RST) busy |-> !start)
    else $error("gcd_engine start while busy");

endmodule

`default_nettype wire

// File: hw/scalar_lcm.sv
/*
 * Scalar modular LCM
 * result = lcm(op_a, op_b) mod modulus, computed as
 * ((op_a / gcd) * op_b) mod modulus with one shared divider
 */

`default_nettype none

module scalar_lcm (
  input  wire logic            CLK,
  input  wire logic            RST,
  input  wire logic            start,
  input  wire vlcm_pkg::data_t op_a,
  input  wire vlcm_pkg::data_t op_b,
  input  wire vlcm_pkg::data_t modulus,
  output logic                 done,
  output vlcm_pkg::data_t      result
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  vlcm_pkg::lcm_state_e state;
  logic                 zero_op;

  // GCD engine
  logic                 gcd_start;
  logic                 gcd_done;
  vlcm_pkg::data_t      gcd_val;

  // Shared divider
  logic                 div_start;
  logic                 div_done;
  vlcm_pkg::wide_t      div_dividend;
  vlcm_pkg::data_t      div_divisor;
  vlcm_pkg::wide_t      div_quo;
  vlcm_pkg::data_t      div_rem;

  // (a / g) * b, always below 2^(2*DATA_W)
  vlcm_pkg::wide_t      prod_q;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  assign zero_op = (op_a == '0) || (op_b == '0);

  // Divider operands by phase, sampled on div_start
  assign div_dividend = (state == vlcm_pkg::LCM_MUL_MOD) ? prod_q : vlcm_pkg::wide_t'(op_a);
  assign div_divisor  = (state == vlcm_pkg::LCM_MUL_MOD) ? modulus : gcd_val;

  // Phase sequencing
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= vlcm_pkg::LCM_IDLE;
      gcd_start <= 1'b0;
      div_start <= 1'b0;
      done      <= 1'b0;
    end else begin
      gcd_start <= 1'b0;
      div_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        vlcm_pkg::LCM_IDLE: begin
          if (start) begin
            // Zero operand skips all arithmetic
            if (zero_op) begin
              state <= vlcm_pkg::LCM_DONE;
            end else begin
              gcd_start <= 1'b1;
              state     <= vlcm_pkg::LCM_GCD;
            end
          end
        end
        vlcm_pkg::LCM_GCD: begin
          if (gcd_done) begin
            div_start <= 1'b1;
            state     <= vlcm_pkg::LCM_DIV_G;
          end
        end
        vlcm_pkg::LCM_DIV_G: begin
          // Product lands with the second divider start
          if (div_done) begin
            div_start <= 1'b1;
            state     <= vlcm_pkg::LCM_MUL_MOD;
          end
        end
        vlcm_pkg::LCM_MUL_MOD: begin
          if (div_done) begin
            state <= vlcm_pkg::LCM_DONE;
          end
        end
        vlcm_pkg::LCM_DONE: begin
          done  <= 1'b1;
          state <= vlcm_pkg::LCM_IDLE;
        end
        default: state <= vlcm_pkg::LCM_IDLE;
      endcase
    end
  end

  // Product and result, held until the next start
  always_ff @(posedge CLK) begin
    if ((state == vlcm_pkg::LCM_DIV_G) && div_done) begin
      prod_q <= div_quo * vlcm_pkg::wide_t'(op_b);
    end
    if ((state == vlcm_pkg::LCM_IDLE) && start && zero_op) begin
      result <= '0;
    end else if ((state == vlcm_pkg::LCM_MUL_MOD) && div_done) begin
      result <= div_rem;
    end
  end

  gcd_engine gcd_engine_i (
    .CLK   (CLK),
    .RST   (RST),
    .start (gcd_start),
    .op_a  (op_a),
    .op_b  (op_b),
    .done  (gcd_done),
    .gcd   (gcd_val)
  );

  seq_divider seq_divider_i (
    .CLK       (CLK),
    .RST       (RST),
    .start     (div_start),
    .dividend  (div_dividend),
    .divisor   (div_divisor),
    .done      (div_done),
    .quotient  (div_quo),
    .remainder (div_rem)
  );

endmodule

`default_nettype wire

// File: hw/seq_divider.sv
/*
 * Sequential restoring divider
 * Wide dividend over a data-width divisor, one quotient bit per cycle,
 * done pulse 2*DATA_W+1 cycles after start
 */

`default_nettype none

`include "vlcm_config.svh"

module seq_divider (
  input  wire logic            CLK,
  input  wire logic            RST,
  input  wire logic            start,
  input  wire vlcm_pkg::wide_t dividend,
  input  wire vlcm_pkg::data_t divisor,
  output logic                 done,
  output vlcm_pkg::wide_t      quotient,
  output vlcm_pkg::data_t      remainder
);

  localparam int DW    = `VLCM_DATA_W;
  localparam int STEPS = 2 * DW;
  localparam int CW    = $clog2(STEPS);

  logic            busy;
  logic [CW-1:0]   step_q;
  vlcm_pkg::data_t dvs_q;
  // Partial remainder with the next dividend bit shifted in
  logic [DW:0]     partial;
  logic [DW:0]     diff;
  logic            fits;

  assign partial = {remainder, quotient[STEPS-1]};
  assign diff    = partial - {1'b0, dvs_q};
  // No borrow out of the trial subtraction
  assign fits    = !diff[DW];

  // Step counter and done pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      step_q <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy   <= 1'b1;
        step_q <= '0;
      end else if (busy) begin
        step_q <= step_q + 1'b1;
        if (step_q == CW'(STEPS - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Quotient register doubles as the dividend shifter
  always_ff @(posedge CLK) begin
    if (start) begin
      quotient  <= dividend;
      remainder <= '0;
      dvs_q     <= divisor;
    end else if (busy) begin
      quotient  <= {quotient[STEPS-2:0], fits};
      remainder <= fits ? diff[DW-1:0] : partial[DW-1:0];
    end
  end

  divisor_nonzero: assert property (@(posedge CLK) disable iff (RST)
    start |-> (divisor != '0))
    else $error("seq_divider started with zero divisor");

endmodule

`default_nettype wire

// File: hw/vector_lcm.sv
/*
 * Vector LCM sequencer
 * Latches length and modulus, pairs the A and B streams into a one-entry
 * buffer, runs the scalar unit and emits results with a last flag
 */

`default_nettype none

module vector_lcm (
  input  wire logic             CLK,
  input  wire logic             RST,
  // Command stream
  input  wire logic             cmd_valid,
  output logic                  cmd_ready,
  input  wire vlcm_pkg::count_t cmd_len,
  input  wire vlcm_pkg::data_t  cmd_mod,
  // Operand streams
  input  wire logic             a_valid,
  output logic                  a_ready,
  input  wire vlcm_pkg::data_t  a_data,
  input  wire logic             b_valid,
  output logic                  b_ready,
  input  wire vlcm_pkg::data_t  b_data,
  // Result stream
  output logic                  out_valid,
  input  wire logic             out_ready,
  output vlcm_pkg::data_t       out_data,
  output logic                  out_last
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  vlcm_pkg::seq_state_e state;
  vlcm_pkg::count_t     len_q;
  vlcm_pkg::count_t     issue_cnt;
  vlcm_pkg::count_t     emit_cnt;
  vlcm_pkg::data_t      mod_q;

  // Pair buffer, filled while the scalar unit runs
  vlcm_pkg::data_t      a_buf;
  vlcm_pkg::data_t      b_buf;
  logic                 a_full;
  logic                 b_full;

  // Scalar unit operands, stable from start to done
  vlcm_pkg::data_t      op_a_q;
  vlcm_pkg::data_t      op_b_q;
  logic                 lcm_start;
  logic                 lcm_done;
  vlcm_pkg::data_t      lcm_res;

  logic cmd_fire, a_fire, b_fire, out_fire;
  logic more_to_issue, launch, out_free, out_load;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  assign more_to_issue = (issue_cnt != len_q);
  assign cmd_ready     = (state == vlcm_pkg::SEQ_IDLE);
  // Accept only elements of the current command
  assign a_ready       = (state != vlcm_pkg::SEQ_IDLE) && !a_full && more_to_issue;
  assign b_ready       = (state != vlcm_pkg::SEQ_IDLE) && !b_full && more_to_issue;

  assign cmd_fire = cmd_valid && cmd_ready;
  assign a_fire   = a_valid && a_ready;
  assign b_fire   = b_valid && b_ready;
  assign out_fire = out_valid && out_ready;

  assign out_free = !out_valid || out_ready;
  assign launch   = (state == vlcm_pkg::SEQ_COLLECT) && a_full && b_full;
  // Pending scalar result moves into the output register
  assign out_load = (state == vlcm_pkg::SEQ_EMIT) && out_free;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= vlcm_pkg::SEQ_IDLE;
      len_q     <= '0;
      issue_cnt <= '0;
      emit_cnt  <= '0;
      a_full    <= 1'b0;
      b_full    <= 1'b0;
      lcm_start <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      lcm_start <= launch;

      if (a_fire) begin
        a_full <= 1'b1;
      end else if (launch) begin
        a_full <= 1'b0;
      end
      if (b_fire) begin
        b_full <= 1'b1;
      end else if (launch) begin
        b_full <= 1'b0;
      end

      // Output register, last flag from the emit index
      if (out_load) begin
        out_valid <= 1'b1;
        out_last  <= (emit_cnt == len_q - vlcm_pkg::count_t'(1));
        emit_cnt  <= emit_cnt + 1'b1;
      end else if (out_fire) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end

      case (state)
        vlcm_pkg::SEQ_IDLE: begin
          if (cmd_fire) begin
            len_q     <= cmd_len;
            issue_cnt <= '0;
            emit_cnt  <= '0;
            state     <= vlcm_pkg::SEQ_COLLECT;
          end
        end
        vlcm_pkg::SEQ_COLLECT: begin
          if (launch) begin
            issue_cnt <= issue_cnt + 1'b1;
            state     <= vlcm_pkg::SEQ_COMPUTE;
          end else if (out_fire && out_last) begin
            // Command finished once the last result is taken
            state <= vlcm_pkg::SEQ_IDLE;
          end
        end
        vlcm_pkg::SEQ_COMPUTE: begin
          if (lcm_done) begin
            state <= vlcm_pkg::SEQ_EMIT;
          end
        end
        vlcm_pkg::SEQ_EMIT: begin
          // Held in the scalar unit while the output is stalled
          if (out_free) begin
            state <= vlcm_pkg::SEQ_COLLECT;
          end
        end
        default: state <= vlcm_pkg::SEQ_IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge CLK) begin
    if (cmd_fire) begin
      mod_q <= cmd_mod;
    end
    if (a_fire) begin
      a_buf <= a_data;
    end
    if (b_fire) begin
      b_buf <= b_data;
    end
    if (launch) begin
      op_a_q <= a_buf;
      op_b_q <= b_buf;
    end
    if (out_load) begin
      out_data <= lcm_res;
    end
  end

  scalar_lcm scalar_lcm_i (
    .CLK     (CLK),
    .RST     (RST),
    .start   (lcm_start),
    .op_a    (op_a_q),
    .op_b    (op_b_q),
    .modulus (mod_q),
    .done    (lcm_done),
    .result  (lcm_res)
  );

  cmd_mod_nonzero: assert property (@(posedge CLK) disable iff (RST)
    cmd_fire |-> (cmd_mod != '0))
    else $error("vector_lcm command with zero modulus");

  cmd_len_nonzero: assert property (@(posedge CLK) disable iff (RST)
    cmd_fire |-> (cmd_len != '0))
    else $error("vector_lcm command with zero length");

endmodule

`default_nettype wire

// File: hw/vlcm_config.svh
/*
 * Vector LCM configuration
 * Element, modulus and count widths shared by the RTL and the testbench
 */

`ifndef VLCM_CONFIG_SVH
`define VLCM_CONFIG_SVH

// Element and modulus width in bits
`define VLCM_DATA_W 16

// Vector length and element index width in bits
`define VLCM_CNT_W 8

`endif

// File: hw/vlcm_pkg.sv
/*
 * Vector LCM package
 * Data, product and count types plus the FSM state encodings
 */

`default_nettype none

`include "vlcm_config.svh"

package vlcm_pkg;

  // Operand, modulus, gcd and result word
  typedef logic [`VLCM_DATA_W-1:0] data_t;
  // Full product of two data words
  typedef logic [2*`VLCM_DATA_W-1:0] wide_t;
  // Vector length and element index
  typedef logic [`VLCM_CNT_W-1:0] count_t;

  // Scalar unit phases
  typedef enum logic [2:0] {
    LCM_IDLE,
    LCM_GCD,
    LCM_DIV_G,
    LCM_MUL_MOD,
    LCM_DONE
  } lcm_state_e;

  // Vector sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_COLLECT,
    SEQ_COMPUTE,
    SEQ_EMIT
  } seq_state_e;

endpackage

`default_nettype wire

// File: hw/vlcm_top.sv
/*
 * Vector LCM subsystem top level
 * Boundary around the vector sequencer
 */

`default_nettype none

module vlcm_top (
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire logic             cmd_valid,
  output logic                  cmd_ready,
  input  wire vlcm_pkg::count_t cmd_len,
  input  wire vlcm_pkg::data_t  cmd_mod,
  input  wire logic             a_valid,
  output logic                  a_ready,
  input  wire vlcm_pkg::data_t  a_data,
  input  wire logic             b_valid,
  output logic                  b_ready,
  input  wire vlcm_pkg::data_t  b_data,
  output logic                  out_valid,
  input  wire logic             out_ready,
  output vlcm_pkg::data_t       out_data,
  output logic                  out_last
);

  vector_lcm vector_lcm_i (
    .CLK       (CLK),
    .RST       (RST),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_len   (cmd_len),
    .cmd_mod   (cmd_mod),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_data    (a_data),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b_data    (b_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last)
  );

endmodule

`default_nettype wire

// File: verif/vlcm_tb.sv
/*
 * Vector LCM testbench
 * Runs a hand-computed table of commands, then random commands with
 * skewed operand streams and output back-pressure, against a reference
 */

`default_nettype none

module vlcm_tb;

  localparam int          ROWS    = 16;
  localparam int          TIMEOUT = 200000;
  localparam int unsigned SEED    = 32'he1e8_b7df;

  logic CLK = 1'b0;
  logic RST;
  logic cmd_valid, cmd_ready, a_valid, a_ready, b_valid, b_ready;
  logic out_valid, out_ready, out_last;
  vlcm_pkg::count_t cmd_len;
  vlcm_pkg::data_t  cmd_mod, a_data, b_data, out_data;

  // Hand-computed table with one row per element
  vlcm_pkg::count_t tbl_len [0:ROWS-1];
  vlcm_pkg::data_t  tbl_mod [0:ROWS-1];
  vlcm_pkg::data_t  tbl_a   [0:ROWS-1];
  vlcm_pkg::data_t  tbl_b   [0:ROWS-1];
  vlcm_pkg::data_t  tbl_exp [0:ROWS-1];

  // Current command's vectors
  vlcm_pkg::data_t vec_a   [0:255];
  vlcm_pkg::data_t vec_b   [0:255];
  vlcm_pkg::data_t vec_exp [0:255];

  int data_errors = 0;
  int flag_errors = 0;
  int timeouts    = 0;
  bit aborted     = 1'b0;

  always #2 CLK = ~CLK;

  vlcm_top vlcm_top_i (
    .CLK(CLK), .RST(RST),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_len(cmd_len), .cmd_mod(cmd_mod),
    .a_valid(a_valid), .a_ready(a_ready), .a_data(a_data),
    .b_valid(b_valid), .b_ready(b_ready), .b_data(b_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data), .out_last(out_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Euclid by remainder then lcm reduced by m
  function automatic vlcm_pkg::data_t lcm_mod_ref(input vlcm_pkg::data_t a,
                                                  input vlcm_pkg::data_t b,
                                                  input vlcm_pkg::data_t m);
    vlcm_pkg::data_t x;
    vlcm_pkg::data_t y;
    vlcm_pkg::data_t t;
    vlcm_pkg::wide_t l;
    if (a == 0 || b == 0) begin
      return '0;
    end
    x = a;
    y = b;
    while (y != 0) begin
      t = x % y;
      x = y;
      y = t;
    end
    l = vlcm_pkg::wide_t'(a / x) * vlcm_pkg::wide_t'(b);
    return vlcm_pkg::data_t'(l % vlcm_pkg::wide_t'(m));
  endfunction

  // Mix of zeros, small and full-width values
  function automatic vlcm_pkg::data_t random_operand();
    if ($urandom % 8 == 0) begin
      return '0;
    end else if ($urandom % 4 == 0) begin
      return vlcm_pkg::data_t'(1 + $urandom % 50);
    end
    return vlcm_pkg::data_t'($urandom);
  endfunction

  task automatic check_data(input string name, input vlcm_pkg::data_t got,
                            input vlcm_pkg::data_t exp);
    if (got !== exp) begin
      data_errors++;
      $display("[FAIL] t=%0t %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic set_row(input int idx, input vlcm_pkg::count_t len,
                         input vlcm_pkg::data_t m, input vlcm_pkg::data_t a,
                         input vlcm_pkg::data_t b, input vlcm_pkg::data_t exp);
    tbl_len[idx] = len;
    tbl_mod[idx] = m;
    tbl_a[idx]   = a;
    tbl_b[idx]   = b;
    tbl_exp[idx] = exp;
  endtask

  task automatic load_table();
    // Coprime, shared factor, equal operands
    set_row(0, 1, 7, 4, 6, 5);
    set_row(1, 1, 100, 7, 9, 63);
    set_row(2, 1, 11, 12, 18, 3);
    set_row(3, 1, 13, 21, 21, 8);
    // Zero operands
    set_row(4, 2, 9, 0, 5, 0);
    set_row(5, 2, 9, 8, 0, 0);
    // Eight element vector
    set_row(6, 8, 1000, 2, 3, 6);
    set_row(7, 8, 1000, 4, 10, 20);
    set_row(8, 8, 1000, 15, 25, 75);
    set_row(9, 8, 1000, 9, 12, 36);
    set_row(10, 8, 1000, 100, 75, 300);
    set_row(11, 8, 1000, 17, 51, 51);
    set_row(12, 8, 1000, 64, 48, 192);
    set_row(13, 8, 1000, 35, 49, 245);
    // Products wider than a data word
    set_row(14, 2, 65521, 65535, 65534, 182);
    set_row(15, 2, 65521, 1000, 999, 16185);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stream drivers called and returning on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_command(input vlcm_pkg::count_t len, input vlcm_pkg::data_t m);
    int waited;
    waited    = 0;
    cmd_valid = 1'b1;
    cmd_len   = len;
    cmd_mod   = m;
    while (!cmd_ready && waited < TIMEOUT && !aborted) begin
      @(negedge CLK);
      waited++;
    end
    if (!cmd_ready) begin
      if (!aborted) begin
        $display("Timeout waiting for cmd_ready");
        timeouts++;
      end
      aborted = 1'b1;
    end else begin
      @(negedge CLK);
    end
    cmd_valid = 1'b0;
  endtask

  task automatic send_a_stream(input vlcm_pkg::count_t len, input bit stall);
    int i;
    int waited;
    for (i = 0; i < len && !aborted; i++) begin
      if (stall) begin
        repeat ($urandom % 4) @(negedge CLK);
      end
      a_valid = 1'b1;
      a_data  = vec_a[i];
      waited  = 0;
      while (!a_ready && waited < TIMEOUT && !aborted) begin
        @(negedge CLK);
        waited++;
      end
      if (!a_ready) begin
        if (!aborted) begin
          $display("Timeout waiting for a_ready on element %0d", i);
          timeouts++;
        end
        aborted = 1'b1;
      end else begin
        @(negedge CLK);
      end
      a_valid = 1'b0;
    end
  endtask

  task automatic send_b_stream(input vlcm_pkg::count_t len, input bit stall);
    int i;
    int waited;
    for (i = 0; i < len && !aborted; i++) begin
      if (stall) begin
        repeat ($urandom % 4) @(negedge CLK);
      end
      b_valid = 1'b1;
      b_data  = vec_b[i];
      waited  = 0;
      while (!b_ready && waited < TIMEOUT && !aborted) begin
        @(negedge CLK);
        waited++;
      end
      if (!b_ready) begin
        if (!aborted) begin
          $display("Timeout waiting for b_ready on element %0d", i);
          timeouts++;
        end
        aborted = 1'b1;
      end else begin
        @(negedge CLK);
      end
      b_valid = 1'b0;
    end
  endtask

  // Result collector checking that a stalled result holds its value
  task automatic recv_stream(input vlcm_pkg::count_t len, input bit stall);
    int              idx;
    int              waited;
    bit              held;
    vlcm_pkg::data_t held_val;
    idx    = 0;
    waited = 0;
    held   = 1'b0;
    while (idx < len && !aborted) begin
      out_ready = stall ? (($urandom % 2) != 0) : 1'b1;
      if (out_valid) begin
        if (held) begin
          check_data("out_data while held", out_data, held_val);
        end
        if (out_ready) begin
          check_data("out_data", out_data, vec_exp[idx]);
          check_flag("out_last", out_last, idx == len - 1);
          idx++;
          held   = 1'b0;
          waited = 0;
        end else begin
          held     = 1'b1;
          held_val = out_data;
        end
      end
      @(negedge CLK);
      waited++;
      if (waited >= TIMEOUT) begin
        $display("Timeout waiting for result %0d of %0d", idx, len);
        timeouts++;
        aborted = 1'b1;
      end
    end
    out_ready = 1'b0;
    // Command closed with nothing extra on the output
    if (!aborted) begin
      check_flag("cmd_ready after last", cmd_ready, 1'b1);
      check_flag("out_valid after last", out_valid, 1'b0);
    end
  endtask

  task automatic run_command(input vlcm_pkg::count_t len, input vlcm_pkg::data_t m,
                             input bit stall);
    send_command(len, m);
    fork
      send_a_stream(len, stall);
      send_b_stream(len, stall);
      recv_stream(len, stall);
    join
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int               r;
    int               k;
    int               c;
    vlcm_pkg::count_t cur_len;
    vlcm_pkg::data_t  cur_mod;
    void'($urandom(SEED));
    RST       = 1'b1;
    cmd_valid = 1'b0;
    cmd_len   = '0;
    cmd_mod   = '0;
    a_valid   = 1'b0;
    a_data    = '0;
    b_valid   = 1'b0;
    b_data    = '0;
    out_ready = 1'b0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    // Idle handshake levels
    check_flag("cmd_ready", cmd_ready, 1'b1);
    check_flag("a_ready", a_ready, 1'b0);
    check_flag("b_ready", b_ready, 1'b0);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("out_last", out_last, 1'b0);

    // Table commands from consecutive rows grouped by length
    load_table();
    r = 0;
    while (r < ROWS && !aborted) begin
      cur_len = tbl_len[r];
      cur_mod = tbl_mod[r];
      for (k = 0; k < cur_len; k++) begin
        vec_a[k]   = tbl_a[r + k];
        vec_b[k]   = tbl_b[r + k];
        vec_exp[k] = tbl_exp[r + k];
      end
      run_command(cur_len, cur_mod, 1'b0);
      r += cur_len;
    end

    // Random commands with stalls on every stream
    for (c = 0; c < 6 && !aborted; c++) begin
      cur_len = vlcm_pkg::count_t'(1 + $urandom % 8);
      if (c % 2 != 0) begin
        cur_mod = vlcm_pkg::data_t'(1 + $urandom % 100);
      end else begin
        cur_mod = vlcm_pkg::data_t'($urandom);
      end
      if (cur_mod == 0) begin
        cur_mod = 1;
      end
      for (k = 0; k < cur_len; k++) begin
        vec_a[k]   = random_operand();
        vec_b[k]   = random_operand();
        vec_exp[k] = lcm_mod_ref(vec_a[k], vec_b[k], cur_mod);
      end
      run_command(cur_len, cur_mod, 1'b1);
    end

    $display("Errors: data %0d, flag %0d, timeouts %0d", data_errors, flag_errors, timeouts);
    if (data_errors == 0 && flag_errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
